//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build rv_core_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module rv_core_tb -f rv_core.f -o rv_core_sim
	./obj_dir/rv_core_sim | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    logic [4:0] shamt;
    logic       lt;

    assign shamt = b[4:0];
    assign lt    = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            // sign fill
            ALU_SRA: result = word_t'($signed(a) >>> shamt);
            ALU_SLT: result = {31'd0, lt};
            default: result = '0;
        endcase
    end

    always_comb begin
        op_legal: assert (op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                     ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT})
            else $error("illegal alu op %0d", op);
    end

endmodule

//--- hdl/decoder.sv
`timescale 1ns/10ps

module decoder import rv_pkg::*; (
    input  word_t instr,
    output ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_reg;
    logic       is_imm;
    logic       supported;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign is_reg = (opcode == OP_REG);
    assign is_imm = (opcode == OP_IMM);

    // sltu shares these opcodes but is not implemented
    assign supported = (is_reg || is_imm) && (funct3 != 3'b011);

    always_comb begin
        ctrl         = '0;
        ctrl.rd      = instr[11:7];
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        // i-type immediate, sign extended
        ctrl.imm     = {{20{instr[31]}}, instr[31:20]};
        ctrl.use_imm = is_imm;

        case (funct3)
            F3_ADD: begin
                if (is_reg && funct7 == F7_ALT) begin
                    ctrl.alu_op = ALU_SUB;
                end else begin
                    ctrl.alu_op = ALU_ADD;
                end
            end
            F3_SLL:  ctrl.alu_op = ALU_SLL;
            F3_SLT:  ctrl.alu_op = ALU_SLT;
            F3_XOR:  ctrl.alu_op = ALU_XOR;
            // bit 30 picks arithmetic shift, for srai as well
            F3_SR:   ctrl.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
            F3_OR:   ctrl.alu_op = ALU_OR;
            F3_AND:  ctrl.alu_op = ALU_AND;
            default: ctrl.alu_op = ALU_ADD;
        endcase

        // no-op for anything else, and x0 stays zero
        if (supported && instr[11:7] != 5'd0) begin
            ctrl.reg_write = 1'b1;
        end else begin
            ctrl.reg_write = 1'b0;
        end

        wr_only_alu_ops: assert (!ctrl.reg_write || is_reg || is_imm)
            else $error("reg_write set for opcode %b", opcode);
    end

endmodule

//--- hdl/instr_fetch.sv
`timescale 1ns/10ps

module instr_fetch import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 32
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  imem_wr,
    input  word_t imem_addr,
    input  word_t imem_data,
    output word_t pc,
    output word_t instr
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];
    word_t pc_next;

    assign pc_next = pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    // program load, also accepted while in reset
    always_ff @(posedge clk) begin
        if (imem_wr) begin
            imem[imem_addr[IDX_W-1:0]] <= imem_data;
        end
    end

    // word index wraps at the memory depth
    assign instr = imem[pc[IDX_W+1:2]];

    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

    wr_in_range: assert property (
        @(posedge clk)
        imem_wr |-> imem_addr < IMEM_DEPTH
    ) else $error("imem write beyond depth: %0d", imem_addr);

endmodule

//--- hdl/register_file.sv
`timescale 1ns/10ps

module register_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    wdata,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        rs1 == 5'd0 |-> rs1_data == '0
    ) else $error("x0 read returned %h", rs1_data);

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    run,
    input  logic    imem_wr,
    input  word_t   imem_addr,
    input  word_t   imem_data,
    output word_t   pc,
    output logic    retire_valid,
    output retire_t retire
);

    word_t instr;
    ctrl_t ctrl;
    word_t rs1_data;
    word_t rs2_data;
    word_t operand_b;
    word_t alu_result;
    logic  rf_we;

    instr_fetch #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) i_instr_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .imem_wr   (imem_wr),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .pc        (pc),
        .instr     (instr)
    );

    decoder i_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // writes only land in run cycles
    assign rf_we = run && ctrl.reg_write;

    register_file i_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (rf_we),
        .rd       (ctrl.rd),
        .wdata    (alu_result),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign operand_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    alu i_alu (
        .a      (rs1_data),
        .b      (operand_b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    // retire port, one cycle behind execution
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire       <= '0;
        end else begin
            retire_valid <= run;
            if (run) begin
                retire.pc        <= pc;
                retire.rd        <= ctrl.rd;
                retire.reg_write <= ctrl.reg_write;
                retire.data      <= alu_result;
            end
        end
    end

endmodule

//--- hdl/rv_pkg.sv
package rv_pkg;

    // data, address and instruction words
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT
    } alu_op_e;

    // major opcodes
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    // funct3 encodings shared by OP_REG and OP_IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // sub / sra select
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;
        logic     reg_write;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
    } ctrl_t;

    // one entry per executed instruction
    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        logic     reg_write;
        word_t    data;
    } retire_t;

endpackage

//--- rv_core.f
hdl/rv_pkg.sv
hdl/instr_fetch.sv
hdl/decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/rv_core.sv
verification/rv_core_tb.sv

//--- verification/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb import rv_pkg::*; ();

    localparam int IMEM_DEPTH     = 32;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IMEM_DEPTH + IMEM_DEPTH + 20;

    logic    clk;
    logic    rst_n;
    logic    run;
    logic    imem_wr;
    word_t   imem_addr;
    word_t   imem_data;
    word_t   pc;
    logic    retire_valid;
    retire_t retire;

    // program words and the expected retire stream
    word_t   prog     [IMEM_DEPTH];
    retire_t exp_ret  [IMEM_DEPTH];
    logic    exp_care [IMEM_DEPTH];
    string   exp_name [IMEM_DEPTH];
    int      n_prog;

    word_t       mregs [32];
    logic [31:0] lcg_state;
    int          ret_idx;
    int          run_cycles;
    int          cycle_count = 0;

    rv_core #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) i_rv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .imem_wr      (imem_wr),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    // reference results written from the instruction set rules
    function automatic word_t ref_result(logic [2:0] f3, logic alt, logic is_reg,
                                         word_t a, word_t b);
        word_t r;
        case (f3)
            F3_ADD: r = (is_reg && alt) ? a + ~b + 32'd1 : a + b;
            F3_SLL: r = a << b[4:0];
            F3_SLT: begin
                if (a[31] != b[31]) begin
                    r = {31'd0, a[31]};
                end else begin
                    r = {31'd0, a < b};
                end
            end
            F3_XOR: r = a ^ b;
            F3_SR:  r = (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffffffff >> b[4:0]) : 32'd0);
            F3_OR:  r = a | b;
            F3_AND: r = a & b;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic retire_ok(retire_t act, retire_t exp, logic care);
        return act.pc == exp.pc && act.rd == exp.rd && act.reg_write == exp.reg_write
            && (!care || act.data == exp.data);
    endfunction

    // appends one instruction and steps the register model
    task automatic add_instr(input word_t instr, input string name);
        logic  is_reg;
        logic  is_imm;
        logic  supported;
        logic  wr;
        word_t a;
        word_t b;
        word_t res;
        is_reg    = instr[6:0] == OP_REG;
        is_imm    = instr[6:0] == OP_IMM;
        supported = (is_reg || is_imm) && instr[14:12] != 3'b011;
        wr        = supported && instr[11:7] != 5'd0;
        a         = mregs[instr[19:15]];
        b         = is_imm ? {{20{instr[31]}}, instr[31:20]} : mregs[instr[24:20]];
        res       = ref_result(instr[14:12], instr[30], is_reg, a, b);
        prog[n_prog]              = instr;
        exp_ret[n_prog].pc        = word_t'(n_prog * 4);
        exp_ret[n_prog].rd        = instr[11:7];
        exp_ret[n_prog].reg_write = wr;
        exp_ret[n_prog].data      = supported ? res : '0;
        exp_care[n_prog]          = supported;
        exp_name[n_prog]          = name;
        if (wr) begin
            mregs[instr[11:7]] = res;
        end
        n_prog++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [11:0] imm;
        logic [4:0]  sh;
        reg_idx_t    ra;
        reg_idx_t    rb;
        word_t       w;
        // x1, x3, x5 positive and x2, x4, x6 negative
        for (int i = 1; i <= 6; i++) begin
            r = next_rand();
            if (i % 2 == 0) begin
                imm = {1'b1, r[10:0]};
            end else begin
                imm = {1'b0, r[10:1], 1'b1};
            end
            add_instr(i_type(imm, 5'd0, F3_ADD, reg_idx_t'(i)), "addi_from_x0");
        end
        add_instr(r_type(7'd0, 5'd2, 5'd1, F3_ADD, 5'd7), "add");
        add_instr(r_type(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd8), "sub");
        add_instr(r_type(F7_ALT, 5'd1, 5'd0, F3_ADD, 5'd9), "sub_underflow");
        add_instr(r_type(7'd0, 5'd2, 5'd1, F3_AND, 5'd10), "and");
        add_instr(r_type(7'd0, 5'd4, 5'd3, F3_OR, 5'd11), "or");
        add_instr(r_type(7'd0, 5'd6, 5'd5, F3_XOR, 5'd12), "xor");
        add_instr(r_type(7'd0, 5'd3, 5'd2, F3_SLL, 5'd13), "sll");
        add_instr(r_type(7'd0, 5'd5, 5'd4, F3_SR, 5'd14), "srl");
        add_instr(r_type(F7_ALT, 5'd1, 5'd6, F3_SR, 5'd15), "sra");
        add_instr(r_type(7'd0, 5'd1, 5'd2, F3_SLT, 5'd16), "slt_neg_pos");
        add_instr(r_type(7'd0, 5'd2, 5'd1, F3_SLT, 5'd17), "slt_pos_neg");
        for (int i = 0; i < 3; i++) begin
            r  = next_rand();
            ra = reg_idx_t'(32'd1 + (r >> 8) % 32'd17);
            rb = reg_idx_t'(32'd1 + (r >> 16) % 32'd17);
            case (r % 32'd9)
                32'd0:   w = r_type(7'd0, rb, ra, F3_ADD, reg_idx_t'(18 + i));
                32'd1:   w = r_type(F7_ALT, rb, ra, F3_ADD, reg_idx_t'(18 + i));
                32'd2:   w = r_type(7'd0, rb, ra, F3_SLL, reg_idx_t'(18 + i));
                32'd3:   w = r_type(7'd0, rb, ra, F3_SLT, reg_idx_t'(18 + i));
                32'd4:   w = r_type(7'd0, rb, ra, F3_XOR, reg_idx_t'(18 + i));
                32'd5:   w = r_type(7'd0, rb, ra, F3_SR, reg_idx_t'(18 + i));
                32'd6:   w = r_type(F7_ALT, rb, ra, F3_SR, reg_idx_t'(18 + i));
                32'd7:   w = r_type(7'd0, rb, ra, F3_OR, reg_idx_t'(18 + i));
                default: w = r_type(7'd0, rb, ra, F3_AND, reg_idx_t'(18 + i));
            endcase
            add_instr(w, "random_rtype");
        end
        // immediate forms on the negative values in x2 and x4
        r  = next_rand();
        sh = {r[4:1], 1'b1};
        add_instr(i_type({7'd0, sh}, 5'd2, F3_SLL, 5'd21), "slli");
        add_instr(i_type({7'd0, sh}, 5'd2, F3_SR, 5'd22), "srli");
        add_instr(i_type({F7_ALT, sh}, 5'd2, F3_SR, 5'd23), "srai");
        r = next_rand();
        add_instr(i_type(r[11:0], 5'd4, F3_XOR, 5'd24), "xori");
        add_instr(i_type(r[23:12], 5'd4, F3_OR, 5'd25), "ori");
        r = next_rand();
        add_instr(i_type(r[11:0], 5'd4, F3_AND, 5'd26), "andi");
        add_instr(i_type(r[23:12], 5'd4, F3_SLT, 5'd27), "slti");
        add_instr(i_type(12'h123, 5'd1, F3_ADD, 5'd0), "addi_to_x0");
        add_instr(r_type(7'd0, 5'd3, 5'd0, F3_ADD, 5'd28), "add_reads_x0");
        // lui x5 decodes as a no-op here
        add_instr({20'h12345, 5'd5, 7'b0110111}, "unsupported_opcode");
        add_instr(r_type(7'd0, 5'd0, 5'd5, F3_ADD, 5'd29), "read_after_noop");
    endtask

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_idx    <= 0;
            run_cycles <= 0;
        end else begin
            if (retire_valid) begin
                ret_idx <= ret_idx + 1;
            end
            if (run) begin
                run_cycles <= run_cycles + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: only %0d of %0d instructions retired", ret_idx, n_prog);
            $display("Result: FAILED");
            $fatal(1, "run did not finish in %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // outputs are registered, so the falling edge sees settled values
    idle_before_run: assert property (
        @(negedge clk) run_cycles == 0 |-> !retire_valid && pc == '0
    ) else begin
        $display("retire_valid or pc changed before run was raised, pc %h", pc);
        $display("Result: FAILED");
        $fatal(1, "idle check failed");
    end

    retire_in_range: assert property (
        @(negedge clk) disable iff (!rst_n)
        retire_valid |-> ret_idx < n_prog
    ) else begin
        $display("more instructions retired than the program holds");
        $display("Result: FAILED");
        $fatal(1, "retire count check failed");
    end

    retire_matches: assert property (
        @(negedge clk) disable iff (!rst_n)
        retire_valid && ret_idx < n_prog |->
            retire_ok(retire, exp_ret[ret_idx], exp_care[ret_idx])
    ) else begin
        $display("MISMATCH %s expected %h actual %h", exp_name[ret_idx], exp_ret[ret_idx],
                 retire);
        $display("Result: FAILED");
        $fatal(1, "retire check failed");
    end

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        imem_wr   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        lcg_state = 32'hfe8d;
        n_prog    = 0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        build_program();

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_prog; i++) begin
            @(negedge clk);
            imem_wr   = 1'b1;
            imem_addr = word_t'(i);
            imem_data = prog[i];
        end
        @(negedge clk);
        imem_wr = 1'b0;
        run     = 1'b1;
        repeat (n_prog) @(negedge clk);
        run = 1'b0;

        while (ret_idx < n_prog) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (retire_valid || pc != word_t'(n_prog * 4)) begin
            $display("MISMATCH final_pc expected %h actual %h", word_t'(n_prog * 4), pc);
            $display("Result: FAILED");
            $fatal(1, "core did not stop after the program");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule
